/* spike_gen_pkg.sv */
package spike_gen_pkg;

  // largest generator count an array may be built with
  localparam int NGENS_MAX = 256;

  // period and countdown share one width
  localparam int PERIOD_W = 16;

  // address tag carried with every spike event
  localparam int TAG_W = 11;

  // time-unit counter, wraps silently
  localparam int CT_W = 10;

  // sweep engine states
  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    READ   = 2'd1,
    DECIDE = 2'd2,
    EMIT   = 2'd3
  } sweep_state_t;

  // source of a memory write
  typedef enum logic [1:0] {
    OP_NONE  = 2'd0,
    OP_HOST  = 2'd1,
    OP_SWEEP = 2'd2
  } prog_op_t;

  // generator index width, never below one bit
  function automatic int gen_idx_w(input int ngens);
    return (ngens > 1) ? $clog2(ngens) : 1;
  endfunction

endpackage

/* gen_prog_if.sv */
`timescale 1ns/1ps

// one generator write, shared by the parameter and countdown memories
interface gen_prog_if import spike_gen_pkg::*; #(
  parameter int NGENS = 8
) ();

  localparam int IDX_W = gen_idx_w(NGENS);

  logic                we;
  prog_op_t            op;
  logic [IDX_W-1:0]    idx;
  logic [PERIOD_W-1:0] period;
  logic [PERIOD_W-1:0] ticks;
  logic [TAG_W-1:0]    tag;

  modport src (
    output we, op, idx, period, ticks, tag
  );

  // static parameters only change on host writes
  modport param_dst (
    input we, op, idx, period, tag
  );

  modport tick_dst (
    input we, idx, ticks
  );

endinterface

/* gen_param_mem.sv */
`timescale 1ns/1ps

module gen_param_mem import spike_gen_pkg::*; #(
  parameter int NGENS     = 8,
  parameter int GEN_IDX_W = 3
) (
  input  logic                 clk,
  gen_prog_if.param_dst        prog,
  input  logic [GEN_IDX_W-1:0] rd_idx,
  output logic [PERIOD_W-1:0]  rd_period,
  output logic [TAG_W-1:0]     rd_tag
);

  // period and tag per generator, block RAM style
  logic [PERIOD_W-1:0] period_mem [NGENS];
  logic [TAG_W-1:0]    tag_mem    [NGENS];

  logic host_wr;

  // sweep writes carry only countdowns
  assign host_wr = prog.we && (prog.op == OP_HOST);

  always_ff @(posedge clk) begin
    if (host_wr) begin
      period_mem[prog.idx] <= prog.period;
      tag_mem[prog.idx]    <= prog.tag;
    end
  end

  // registered read, data one cycle after rd_idx
  always_ff @(posedge clk) begin
    rd_period <= period_mem[rd_idx];
    rd_tag    <= tag_mem[rd_idx];
  end

endmodule

/* gen_tick_mem.sv */
`timescale 1ns/1ps

module gen_tick_mem import spike_gen_pkg::*; #(
  parameter int NGENS     = 8,
  parameter int GEN_IDX_W = 3
) (
  input  logic                 clk,
  input  logic                 rst,
  gen_prog_if.tick_dst         prog,
  input  logic [GEN_IDX_W-1:0] rd_idx,
  output logic [PERIOD_W-1:0]  rd_ticks
);

  // countdown per generator
  logic [PERIOD_W-1:0] ticks_mem [NGENS];

  // host load or sweep update, never both in one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NGENS; i++) begin
        ticks_mem[i] <= '0;
      end
    end else if (prog.we) begin
      ticks_mem[prog.idx] <= prog.ticks;
    end
  end

  // read register
  always_ff @(posedge clk) begin
    rd_ticks <= ticks_mem[rd_idx];
  end

endmodule

/* spike_sweep.sv */
`timescale 1ns/1ps

module spike_sweep import spike_gen_pkg::*; #(
  parameter int NGENS     = 8,
  parameter int GEN_IDX_W = 3
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 unit_pulse,
  input  logic [GEN_IDX_W:0]   gens_used,
  input  logic [NGENS-1:0]     gens_en,
  input  logic                 prog_v,
  output logic                 prog_a,
  input  logic [GEN_IDX_W-1:0] prog_gen_idx,
  input  logic [PERIOD_W-1:0]  prog_period,
  input  logic [PERIOD_W-1:0]  prog_ticks,
  input  logic [TAG_W-1:0]     prog_tag,
  gen_prog_if.src              wr,
  output logic [GEN_IDX_W-1:0] rd_idx,
  input  logic [PERIOD_W-1:0]  rd_period,
  input  logic [TAG_W-1:0]     rd_tag,
  input  logic [PERIOD_W-1:0]  rd_ticks,
  output logic                 out_v,
  input  logic                 out_a,
  output logic [TAG_W-1:0]     out_tag,
  output logic [CT_W-1:0]      out_ct
);

  localparam logic [GEN_IDX_W:0] NGENS_CNT = NGENS[GEN_IDX_W:0];

  sweep_state_t state;

  logic [GEN_IDX_W-1:0] gen_idx;
  logic [CT_W-1:0]      unit_ct;
  logic                 pending;
  logic                 prog_wr;

  // configuration held for one sweep
  logic [GEN_IDX_W:0]   used_q;
  logic [NGENS-1:0]     en_q;

  logic                 start;
  logic                 prog_acc;
  logic                 gen_en;
  logic                 fire;
  logic                 advance;
  logic                 last_gen;
  logic                 sweep_we;
  logic [PERIOD_W-1:0]  next_ticks;
  logic [GEN_IDX_W:0]   used_clamped;

  assign start = (state == IDLE) && (unit_pulse || pending);

  // host gets the memories only in a quiet idle cycle
  assign prog_acc = (state == IDLE) && !pending && !unit_pulse && prog_v &&
                    !prog_wr && !prog_a;

  assign gen_en   = en_q[gen_idx];
  assign fire     = (state == DECIDE) && gen_en && (rd_ticks == '0);
  assign advance  = ((state == DECIDE) && !fire) || ((state == EMIT) && out_a);
  assign last_gen = ({1'b0, gen_idx} + 1'b1) >= used_q;

  // reload on fire, else count down
  assign next_ticks = (rd_ticks == '0) ? rd_period - 1'b1 : rd_ticks - 1'b1;

  // disabled generators keep their countdown
  assign sweep_we = (state == DECIDE) && gen_en;

  assign used_clamped = (gens_used > NGENS_CNT) ? NGENS_CNT : gens_used;

  // rd data for gen_idx is valid in DECIDE
  assign rd_idx = gen_idx;

  // shared write port, host write never overlaps a sweep
  assign wr.we     = prog_wr || sweep_we;
  assign wr.op     = prog_wr ? OP_HOST : (sweep_we ? OP_SWEEP : OP_NONE);
  assign wr.idx    = prog_wr ? prog_gen_idx : gen_idx;
  assign wr.period = prog_period;
  assign wr.ticks  = prog_wr ? prog_ticks : next_ticks;
  assign wr.tag    = prog_tag;

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= IDLE;
      gen_idx <= '0;
      unit_ct <= '0;
      pending <= 1'b0;
      prog_wr <= 1'b0;
      prog_a  <= 1'b0;
      out_v   <= 1'b0;
    end else begin
      // write the cycle after acceptance, ack one later
      prog_wr <= prog_acc;
      prog_a  <= prog_wr;

      // one pulse remembered during a sweep
      if ((state != IDLE) && unit_pulse) begin
        pending <= 1'b1;
      end

      case (state)
        IDLE: begin
          if (start) begin
            unit_ct <= unit_ct + 1'b1;
            pending <= pending && unit_pulse;
            gen_idx <= '0;
            if (used_clamped != '0) begin
              state <= READ;
            end
          end
        end
        READ: begin
          state <= DECIDE;
        end
        DECIDE: begin
          if (fire) begin
            out_v <= 1'b1;
            state <= EMIT;
          end
        end
        EMIT: begin
          if (out_a) begin
            out_v <= 1'b0;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase

      // next generator or end of sweep
      if (advance) begin
        if (last_gen) begin
          state <= IDLE;
        end else begin
          gen_idx <= gen_idx + 1'b1;
          state   <= READ;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      used_q <= used_clamped;
      en_q   <= gens_en;
    end
    // event payload, held while out_v waits for out_a
    if (fire) begin
      out_tag <= rd_tag;
      out_ct  <= unit_ct;
    end
  end

endmodule

/* spike_generator_array.sv */
`timescale 1ns/1ps

module spike_generator_array import spike_gen_pkg::*; #(
  parameter int  NGENS     = 8,
  localparam int GEN_IDX_W = gen_idx_w(NGENS)
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 prog_v,
  output logic                 prog_a,
  input  logic [GEN_IDX_W-1:0] prog_gen_idx,
  input  logic [PERIOD_W-1:0]  prog_period,
  input  logic [PERIOD_W-1:0]  prog_ticks,
  input  logic [TAG_W-1:0]     prog_tag,
  input  logic [GEN_IDX_W:0]   gens_used,
  input  logic [NGENS-1:0]     gens_en,
  input  logic                 unit_pulse,
  output logic                 out_v,
  input  logic                 out_a,
  output logic [TAG_W-1:0]     out_tag,
  output logic [CT_W-1:0]      out_ct
);

  if (NGENS > NGENS_MAX) begin : g_ngens_check
    $error("NGENS above NGENS_MAX");
  end

  // memory read path
  logic [GEN_IDX_W-1:0] rd_idx;
  logic [PERIOD_W-1:0]  rd_period;
  logic [TAG_W-1:0]     rd_tag;
  logic [PERIOD_W-1:0]  rd_ticks;

  gen_prog_if #(.NGENS(NGENS)) prog_bus ();

  gen_param_mem #(
    .NGENS     (NGENS),
    .GEN_IDX_W (GEN_IDX_W)
  ) u_gen_param_mem (
    .clk       (clk),
    .prog      (prog_bus.param_dst),
    .rd_idx    (rd_idx),
    .rd_period (rd_period),
    .rd_tag    (rd_tag)
  );

  gen_tick_mem #(
    .NGENS     (NGENS),
    .GEN_IDX_W (GEN_IDX_W)
  ) u_gen_tick_mem (
    .clk      (clk),
    .rst      (rst),
    .prog     (prog_bus.tick_dst),
    .rd_idx   (rd_idx),
    .rd_ticks (rd_ticks)
  );

  spike_sweep #(
    .NGENS     (NGENS),
    .GEN_IDX_W (GEN_IDX_W)
  ) u_spike_sweep (
    .clk          (clk),
    .rst          (rst),
    .unit_pulse   (unit_pulse),
    .gens_used    (gens_used),
    .gens_en      (gens_en),
    .prog_v       (prog_v),
    .prog_a       (prog_a),
    .prog_gen_idx (prog_gen_idx),
    .prog_period  (prog_period),
    .prog_ticks   (prog_ticks),
    .prog_tag     (prog_tag),
    .wr           (prog_bus.src),
    .rd_idx       (rd_idx),
    .rd_period    (rd_period),
    .rd_tag       (rd_tag),
    .rd_ticks     (rd_ticks),
    .out_v        (out_v),
    .out_a        (out_a),
    .out_tag      (out_tag),
    .out_ct       (out_ct)
  );

endmodule

/* spike_generator_array_chk.sv */
`timescale 1ns/1ps

module spike_generator_array_chk import spike_gen_pkg::*; (
  input logic              clk,
  input logic              rst,
  input logic              prog_a,
  input logic              out_v,
  input logic              out_a,
  input logic [TAG_W-1:0]  out_tag,
  input logic [CT_W-1:0]   out_ct,
  input sweep_state_t      state
);

  // number of assertion failures so far
  int fail_count = 0;

  // event held until the sink takes it
  a_out_hold: assert property (@(posedge clk) disable iff (rst)
    out_v && !out_a |=> out_v && $stable(out_tag) && $stable(out_ct))
    else begin
      fail_count++;
      $error("output event dropped or changed before out_a");
    end

  a_prog_a_pulse: assert property (@(posedge clk) disable iff (rst)
    prog_a |=> !prog_a)
    else begin
      fail_count++;
      $error("prog_a high for two cycles");
    end

  // quiet handshakes right out of reset
  a_reset_quiet: assert property (@(posedge clk)
    rst |=> !prog_a && !out_v && (state == IDLE))
    else begin
      fail_count++;
      $error("handshake or state not cleared by reset");
    end

endmodule

bind spike_sweep spike_generator_array_chk u_spike_generator_array_chk (
  .clk     (clk),
  .rst     (rst),
  .prog_a  (prog_a),
  .out_v   (out_v),
  .out_a   (out_a),
  .out_tag (out_tag),
  .out_ct  (out_ct),
  .state   (state)
);

/* spike_generator_array_tb.sv */
`timescale 1ns/1ps

module spike_generator_array_tb import spike_gen_pkg::*; ();

  localparam int NGENS   = 8;
  localparam int IDX_W   = gen_idx_w(NGENS);
  localparam int TIMEOUT = 1000;

  logic                clk;
  logic                rst;
  logic                prog_v;
  logic                prog_a;
  logic [IDX_W-1:0]    prog_gen_idx;
  logic [PERIOD_W-1:0] prog_period;
  logic [PERIOD_W-1:0] prog_ticks;
  logic [TAG_W-1:0]    prog_tag;
  logic [IDX_W:0]      gens_used;
  logic [NGENS-1:0]    gens_en;
  logic                unit_pulse;
  logic                out_v;
  logic                out_a;
  logic [TAG_W-1:0]    out_tag;
  logic [CT_W-1:0]     out_ct;

  logic [19:0] lfsr_state;
  int          expected_tag[$];
  int          expected_ct[$];

  spike_generator_array #(.NGENS(NGENS)) u_spike_generator_array (
    .clk          (clk),
    .rst          (rst),
    .prog_v       (prog_v),
    .prog_a       (prog_a),
    .prog_gen_idx (prog_gen_idx),
    .prog_period  (prog_period),
    .prog_ticks   (prog_ticks),
    .prog_tag     (prog_tag),
    .gens_used    (gens_used),
    .gens_en      (gens_en),
    .unit_pulse   (unit_pulse),
    .out_v        (out_v),
    .out_a        (out_a),
    .out_tag      (out_tag),
    .out_ct       (out_ct)
  );

  always #2 clk = ~clk;

  // 20-bit fibonacci lfsr with taps 20 and 17
  function automatic logic [19:0] lfsr_step(input logic [19:0] s);
    return {s[18:0], s[19] ^ s[16]};
  endfunction

  // assertion failures counted by the bound checker
  function automatic int assert_fails();
    return u_spike_generator_array.u_spike_sweep.u_spike_generator_array_chk.fail_count;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "run aborted");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("** Error: %s got 0x%0h expected 0x%0h", name, got, expected);
      $display("Simulation failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic wait_idle(input string what);
    int n;
    n = 0;
    while (u_spike_generator_array.u_spike_sweep.state != IDLE) begin
      if (n == TIMEOUT) abort_run({"timeout: sweep never returned to idle after ", what});
      @(posedge clk);
      #1;
      n++;
    end
  endtask

  task automatic program_gen(input int idx, input int period, input int ticks, input int tag);
    int n;
    n = 0;
    prog_gen_idx = IDX_W'(idx);
    prog_period  = PERIOD_W'(period);
    prog_ticks   = PERIOD_W'(ticks);
    prog_tag     = TAG_W'(tag);
    prog_v       = 1'b1;
    @(posedge clk);
    #1;
    while (!prog_a) begin
      if (n == TIMEOUT) abort_run("timeout: programming write never acknowledged");
      @(posedge clk);
      #1;
      n++;
    end
    // idle request is written after one edge and acknowledged after the next
    check_value("prog_a latency", 32'(n + 1), 32'd2);
    // request drops in the cycle after the ack
    @(posedge clk);
    #1;
    prog_v = 1'b0;
  endtask

  task automatic pulse_units(input int count);
    for (int i = 0; i < count; i++) begin
      unit_pulse = 1'b1;
      @(posedge clk);
      #1;
      unit_pulse = 1'b0;
      wait_idle("unit pulse");
    end
  endtask

  // random back-pressure from one lfsr step per bit
  always @(posedge clk) begin
    #1;
    lfsr_state = lfsr_step(lfsr_state);
    out_a      = lfsr_state[0];
  end

  // mid-cycle sample of an event that transfers at the next rising edge
  always @(negedge clk) begin
    if (assert_fails() != 0) begin
      abort_run("a bound assertion on the sweep engine failed");
    end
    if (!rst && out_v && out_a) begin
      if (expected_tag.size() == 0) begin
        abort_run("output event arrived with no expected event left");
      end else begin
        check_value("out_tag", 32'(out_tag), expected_tag.pop_front());
        check_value("out_ct", 32'(out_ct), expected_ct.pop_front());
      end
    end
  end

  initial begin
    int         fd;
    int         code;
    int         a;
    int         b;
    int         c;
    int         d;
    logic [7:0] kind;
    logic [8*128-1:0] line_buf;
    clk          = 1'b0;
    rst          = 1'b1;
    prog_v       = 1'b0;
    prog_gen_idx = '0;
    prog_period  = '0;
    prog_ticks   = '0;
    prog_tag     = '0;
    gens_used    = '0;
    gens_en      = '0;
    unit_pulse   = 1'b0;
    out_a        = 1'b0;
    lfsr_state   = 20'd96006;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    fd = $fopen("spike_cases.txt", "r");
    if (fd == 0) abort_run("could not open spike_cases.txt");
    code = $fscanf(fd, " %c", kind);
    while (code == 1) begin
      case (kind)
        "#": code = $fgets(line_buf, fd);
        "P": begin
          code = $fscanf(fd, "%d %d %d %d", a, b, c, d);
          program_gen(a, b, c, d);
        end
        "C": begin
          code = $fscanf(fd, "%d %h", a, b);
          gens_used = (IDX_W+1)'(a);
          gens_en   = NGENS'(b);
        end
        "U": begin
          code = $fscanf(fd, "%d", a);
          pulse_units(a);
        end
        "E": begin
          code = $fscanf(fd, "%d %d", a, b);
          expected_tag.push_back(a);
          expected_ct.push_back(b);
        end
        default: abort_run("unknown line kind in spike_cases.txt");
      endcase
      code = $fscanf(fd, " %c", kind);
    end
    $fclose(fd);
    check_value("missing events", 32'(expected_tag.size()), 32'd0);
    // quiet window where the monitor flags any stray event
    repeat (200) @(posedge clk);
    #1;
    if (assert_fails() != 0) begin
      abort_run("a bound assertion on the sweep engine failed");
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

/* spike_cases.txt */
# P idx period ticks tag | C gens_used gens_en(hex) | U pulse count
# E tag unit, listed ahead of the U line that produces it
# gen 0 every 2 units, gen 1 every 4
P 0 2 0 512
P 1 4 2 513
C 2 03
E 512 1
E 512 3
E 513 3
E 512 5
E 512 7
E 513 7
U 7
# gen 0 disabled, countdown held
C 2 02
U 2
C 2 03
E 512 11
E 513 11
U 3
# gen 1 outside gens_used, frozen
C 1 03
E 512 13
E 512 15
U 3
C 2 03
E 512 17
E 513 18
U 3
# gen 1 reprogrammed, gen 2 fires every unit
P 1 3 1 700
P 2 1 0 5
C 3 07
E 512 19
E 5 19
E 700 20
E 5 20
E 512 21
E 5 21
E 5 22
E 512 23
E 700 23
E 5 23
U 5

/* verilog.f */
spike_gen_pkg.sv
gen_prog_if.sv
gen_param_mem.sv
gen_tick_mem.sv
spike_sweep.sv
spike_generator_array.sv
spike_generator_array_chk.sv
spike_generator_array_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f \
  --top-module spike_generator_array_tb -o sim_tb

status=0
output=$(./obj_dir/sim_tb 2>&1) || status=$?
echo "$output"

if grep -q "Simulation completed successfully" <<< "$output"; then
  exit 0
fi
echo "simulation exit status ${status}"
exit 1
